// ==== build.f ====
+incdir+include
source/image_pkg.sv
source/fifo.sv
source/grayscale.sv
source/pixel_position.sv
source/crop_gate.sv
source/image_crop_top.sv
testbench/clock_gen.sv
testbench/image_crop_tb.sv

// ==== sim.sh ====
#!/bin/sh
# build the image crop testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
    --top-module image_crop_tb -o image_crop_sim > build.log 2>&1 ||
    { echo "build failed, see build.log"; exit 1; }
./obj_dir/image_crop_sim > sim.log 2>&1
grep -q "All checks passed" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/image_crop_tb.sv ====
// image crop stage testbench
`timescale 1ns/10ps
`default_nettype none

`include "image_macros.svh"

module image_crop_tb
    import image_pkg::*;
();

    localparam int FRAME_PIXELS = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int TOTAL_PIXELS = 2 * FRAME_PIXELS;
    localparam int WINDOW_PIXELS = (`CROP_X_LAST - `CROP_X_FIRST + 1)
                                 * (`CROP_Y_LAST - `CROP_Y_FIRST + 1);
    localparam int STALL_FIRST = 16;
    localparam int STALL_CYCLES = 808;
    // twice the run: two cycles per pixel plus the stall
    localparam int TIMEOUT_CYCLES = 2 * (2 * TOTAL_PIXELS + STALL_CYCLES);
    // queued pixels each clear in two cycles once nothing waits on the output
    localparam int DRAIN_CYCLES = 2 * (`FIFO_DEPTH + 1) + 2;

    logic        clock;
    logic        reset;
    logic        in_wr_en;
    logic [23:0] in_din;
    logic        in_full;
    logic        out_rd_en;
    logic [7:0]  out_dout;
    logic        out_empty;

    // expected levels, in order
    gray_t expected_q[$];
    int    received = 0;
    int    cycle_count = 0;
    logic  saw_in_full;
    logic  all_sent;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic gray_t channel_average(input rgb_t pixel);
        int total;
        total = int'(pixel.red) + int'(pixel.green) + int'(pixel.blue);
        return gray_t'(total / 3);
    endfunction

    function automatic logic inside_window(input int n);
        int x;
        int y;
        x = (n % FRAME_PIXELS) % `IMG_WIDTH;
        y = (n % FRAME_PIXELS) / `IMG_WIDTH;
        return (x >= `CROP_X_FIRST) && (x <= `CROP_X_LAST)
            && (y >= `CROP_Y_FIRST) && (y <= `CROP_Y_LAST);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    clock_gen #(.HALF_PERIOD(50), .RESET_CYCLES(10)) clock_gen0 (
        .clock (clock),
        .reset (reset)
    );

    image_crop_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d outputs seen",
                                cycle_count, received, 2 * WINDOW_PIXELS));
        end
    end

    initial begin : main
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        @(negedge reset);
        assert (out_empty == 1'b1) else abort_run("Mismatch out_empty: got 0x0 expected 0x1");
        assert (in_full == 1'b0) else abort_run("Mismatch in_full: got 0x1 expected 0x0");

        wait (received == 2 * WINDOW_PIXELS && all_sent);
        // let the out-of-window tail of the second frame drain
        repeat (DRAIN_CYCLES) @(negedge clock);
        assert (out_empty == 1'b1) else abort_run("output FIFO not empty after the last level");
        $display("All checks passed");
        $finish;
    end

    // writes at most every other cycle, the converter's own rate
    initial begin : producer
        logic [31:0] rand_state;
        rgb_t pixel;
        int n;
        rand_state = 32'd34;
        n = 0;
        all_sent = 1'b0;
        @(negedge reset);
        while (n < TOTAL_PIXELS) begin
            @(negedge clock);
            if (in_full == 1'b0 && in_wr_en == 1'b0) begin
                rand_state = lcg_next(rand_state);
                pixel = rgb_t'(rand_state[31:8]);
                // both extremes land inside the window
                if (n == 10) begin
                    pixel = '1;
                end else if (n == 27) begin
                    pixel = '0;
                end
                if (inside_window(n)) begin
                    expected_q.push_back(channel_average(pixel));
                end
                in_wr_en = 1'b1;
                in_din   = pixel;
                n++;
            end else begin
                in_wr_en = 1'b0;
            end
        end
        @(negedge clock);
        in_wr_en = 1'b0;
        all_sent = 1'b1;
    end

    // reads three cycles in four, with one long stall
    initial begin : consumer
        int c;
        logic stalled;
        c = 0;
        saw_in_full = 1'b0;
        @(negedge reset);
        forever begin
            @(negedge clock);
            stalled = (c >= STALL_FIRST) && (c < STALL_FIRST + STALL_CYCLES);
            if (stalled && in_full) begin
                saw_in_full = 1'b1;
            end
            if (c == STALL_FIRST + STALL_CYCLES) begin
                assert (saw_in_full) else abort_run("in_full never rose during the output stall");
            end
            out_rd_en = !stalled && (c % 4 != 3);
            if (out_rd_en && !out_empty) begin
                assert (expected_q.size() > 0) else abort_run("output level with none expected");
                assert (out_dout == expected_q[0]) else abort_run($sformatf(
                    "Mismatch out_dout: got 0x%02h expected 0x%02h", out_dout, expected_q[0]));
                void'(expected_q.pop_front());
                received++;
            end
            c++;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD = 50,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // release on a falling edge, away from the DUT's sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/image_crop_top.sv ====
// image crop grayscale stage
`timescale 1ns/10ps
`default_nettype none

`include "image_macros.svh"

module image_crop_top
    import image_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_wr_en,
    input  logic [23:0] in_din,
    output logic        in_full,
    input  logic        out_rd_en,
    output logic [7:0]  out_dout,
    output logic        out_empty
);

    // input FIFO to converter
    logic in_rd_en;
    logic in_empty;
    rgb_t in_dout;

    // converter to gate
    logic  gray_wr_en;
    logic  gray_full;
    gray_t gray_din;

    coord_x_t x;
    coord_y_t y;

    // gate to output FIFO
    logic  out_wr_en;
    logic  out_full;
    gray_t out_din;

    fifo #(
        .DATA_WIDTH ($bits(rgb_t)),
        .DEPTH      (`FIFO_DEPTH)
    ) input_fifo0 (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    grayscale grayscale0 (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (in_rd_en),
        .in_empty   (in_empty),
        .in_dout    (in_dout),
        .gray_wr_en (gray_wr_en),
        .gray_full  (gray_full),
        .gray_din   (gray_din)
    );

    pixel_position pixel_position0 (
        .clock      (clock),
        .reset      (reset),
        .gray_wr_en (gray_wr_en),
        .gray_full  (gray_full),
        .x          (x),
        .y          (y)
    );

    crop_gate crop_gate0 (
        .gray_wr_en (gray_wr_en),
        .gray_din   (gray_din),
        .gray_full  (gray_full),
        .x          (x),
        .y          (y),
        .out_wr_en  (out_wr_en),
        .out_din    (out_din),
        .out_full   (out_full)
    );

    fifo #(
        .DATA_WIDTH ($bits(gray_t)),
        .DEPTH      (`FIFO_DEPTH)
    ) output_fifo0 (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_din),
        .full  (out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

// ==== source/crop_gate.sv ====
// crop window gate
`timescale 1ns/10ps
`default_nettype none

`include "image_macros.svh"

module crop_gate
    import image_pkg::*;
(
    input  logic     gray_wr_en,
    input  gray_t    gray_din,
    output logic     gray_full,
    input  coord_x_t x,
    input  coord_y_t y,
    output logic     out_wr_en,
    output gray_t    out_din,
    input  logic     out_full
);

    logic x_inside, y_inside, in_window;

    assign x_inside = (x >= coord_x_t'(`CROP_X_FIRST)) && (x <= coord_x_t'(`CROP_X_LAST));
    assign y_inside = (y >= coord_y_t'(`CROP_Y_FIRST)) && (y <= coord_y_t'(`CROP_Y_LAST));
    assign in_window = x_inside && y_inside;

    // inside, pass write and back-pressure through
    // outside, accept at once and drop
    assign out_wr_en = gray_wr_en && in_window;
    assign out_din   = gray_din;
    assign gray_full = in_window ? out_full : 1'b0;

endmodule

`default_nettype wire

// ==== source/pixel_position.sv ====
// raster position tracker
`timescale 1ns/10ps
`default_nettype none

`include "image_macros.svh"

module pixel_position
    import image_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     gray_wr_en,
    input  logic     gray_full,
    output coord_x_t x,
    output coord_y_t y
);

    logic accepted;

    assign accepted = gray_wr_en && !gray_full;

    // x and y name the pixel now on offer
    always_ff @(posedge clock or posedge reset) begin
        if (reset == 1'b1) begin
            x <= '0;
            y <= '0;
        end else if (accepted) begin
            if (x == coord_x_t'(`IMG_WIDTH - 1)) begin
                x <= '0;
                // end of line, maybe end of frame
                if (y == coord_y_t'(`IMG_HEIGHT - 1)) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/grayscale.sv ====
// rgb to gray level converter
`timescale 1ns/10ps
`default_nettype none

module grayscale
    import image_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    output logic  in_rd_en,
    input  logic  in_empty,
    input  rgb_t  in_dout,
    output logic  gray_wr_en,
    input  logic  gray_full,
    output gray_t gray_din
);

    typedef enum logic [0:0] {S0, S1} state_t;

    state_t state, next_state;
    gray_t gs, gs_c;
    logic [9:0] sum;

    // wide enough for three full channels
    assign sum = {2'b0, in_dout.red} + {2'b0, in_dout.green} + {2'b0, in_dout.blue};

    always_ff @(posedge clock or posedge reset) begin
        if (reset == 1'b1) begin
            state <= S0;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        gs <= gs_c;
    end

    always_comb begin
        in_rd_en   = 1'b0;
        gray_wr_en = 1'b0;
        gray_din   = '0;
        next_state = state;
        gs_c       = gs;

        case (state)
            S0: begin
                // pop and average in one cycle
                if (in_empty == 1'b0) begin
                    in_rd_en   = 1'b1;
                    gs_c       = gray_t'(sum / 10'd3);
                    next_state = S1;
                end
            end

            S1: begin
                // hold the level until downstream has room
                if (gray_full == 1'b0) begin
                    gray_wr_en = 1'b1;
                    gray_din   = gs;
                    next_state = S0;
                end
            end

            default: begin
                next_state = S0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fifo.sv ====
// first-word-fall-through FIFO
`timescale 1ns/10ps
`default_nettype none

`include "image_macros.svh"

module fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] din,
    output logic                  full,
    input  logic                  rd_en,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr, wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr, do_rd;

    // requests against the wrong flag are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset == 1'b1) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // head entry shows while not empty
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== source/image_pkg.sv ====
// image pixel and coordinate types
`default_nettype none

`include "image_macros.svh"

package image_pkg;

    // 24-bit colour pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // averaged gray level
    typedef logic [7:0] gray_t;

    // raster position counters
    typedef logic [$clog2(`IMG_WIDTH)-1:0] coord_x_t;
    typedef logic [$clog2(`IMG_HEIGHT)-1:0] coord_y_t;

endpackage

`default_nettype wire

// ==== include/image_macros.svh ====
// image size and crop window
`ifndef IMAGE_MACROS_SVH
`define IMAGE_MACROS_SVH

// frame geometry in pixels
`define IMG_WIDTH 8
`define IMG_HEIGHT 6

// crop window, bounds inclusive
`define CROP_X_FIRST 2
`define CROP_X_LAST 5
`define CROP_Y_FIRST 1
`define CROP_Y_LAST 3

// entries in each stream FIFO
`define FIFO_DEPTH 16

`endif
